/* files.f */
+incdir+include
logic/rv32Pkg.sv
logic/controlIf.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/controlFsm.sv
logic/coreDatapath.sv
logic/multicycleCore.sv
testbench/storeChecker.sv
testbench/coreTb.sv

/* testbench/coreTb.sv */
// testbench top with clock, reset, memory model and random program generator
// plus the instruction-set reference model and the watchdog
`timescale 1ns/1ps
`include "rv32Params.svh"

module coreTb;
  import rv32Pkg::*;

  localparam int ClkPeriod = 40;
  localparam int NumTests  = 8;
  localparam int NumSlots  = 40;   // random instruction groups per program
  localparam int MemWords  = 1024; // code below 0x400, data at 0x800, results at 0xC00

  logic  clk;
  logic  reset;
  addr_t memAddr;
  data_t memWriteData;
  logic  memWrite;
  data_t memReadData;

  data_t       mem [MemWords];
  data_t       refMem [MemWords]; // copy that the model runs on
  logic [31:0] lfsr;
  int          wp;                // next program word
  int          testId;
  int          progLen;
  int          expectedStores;
  int          passCount;
  int          failCount;
  logic        running = 1'b0;
  time         deadline = 0;

  multicycleCore UUT (
    .clk(clk), .reset(reset), .memAddr(memAddr), .memWriteData(memWriteData),
    .memWrite(memWrite), .memReadData(memReadData)
  );

  storeChecker scoreboard (
    .clk(clk), .reset(reset), .memWrite(memWrite), .memAddr(memAddr),
    .memWriteData(memWriteData)
  );

  assign memReadData = mem[memAddr[11:2]]; // combinational read

  always @(posedge clk) begin
    if (memWrite === 1'b1) begin
      mem[memAddr[11:2]] <= memWriteData;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic int randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr[0]};
    end
    return int'(v);
  endfunction

  function automatic data_t fillWord(input int idx);
    data_t a;
    a = data_t'(idx) << 2;
    return (a * 32'h9E37_79B9) ^ 32'h5A0F_C3A5;
  endfunction

  function automatic data_t encR(input logic [6:0] f7, input int rs2, rs1,
                                 input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic data_t encI(input logic [11:0] imm, input int rs1,
                                 input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic data_t encS(input logic [11:0] imm, input int rs2, rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // branch offset fixed at 8
  function automatic data_t encB(input int rs2, rs1, input logic [2:0] f3);
    return {7'b0, 5'(rs2), 5'(rs1), f3, 5'b01000, 7'b1100011};
  endfunction

  function automatic data_t encJ(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic data_t encU(input logic [19:0] imm, input int rd, input logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  task automatic emit(input data_t w);
    mem[wp] = w;
    refMem[wp] = w;
    wp++;
  endtask

  task automatic fillMemory();
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = fillWord(i);
      refMem[i] = fillWord(i);
    end
  endtask

  task automatic buildProgram();
    int          kind;
    int          rd;
    int          rs1;
    int          rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    fillMemory();
    wp = 0;
    emit(encU(20'h00001, 8, 7'b0110111)); // x8 = 0x1000, base for data and results
    for (int r = 1; r < 8; r++) begin
      emit(encU(20'(randBits(20)), r, 7'b0110111));
      emit(encI(12'(randBits(12)), r, 3'b000, r, 7'b0010011));
    end
    for (int s = 0; s < NumSlots; s++) begin
      kind = randBits(4);
      rd = randBits(3); // x0 included
      rs1 = randBits(3);
      rs2 = randBits(3);
      f3 = 3'(randBits(3));
      alt = 1'(randBits(1));
      imm = 12'(randBits(12));
      if (kind < 6) begin
        emit(encR({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0}, rs2, rs1, f3, rd));
      end else if (kind < 9) begin
        if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
        if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]}; // srli or srai
        emit(encI(imm, rs1, f3, rd, 7'b0010011));
      end else if (kind == 9) begin
        emit(encU(20'(randBits(20)), rd, 7'b0110111));
      end else if (kind == 10) begin
        emit(encU(20'(randBits(20)), rd, 7'b0010111));
      end else if (kind == 11) begin
        imm = {1'b1, 3'b0, imm[5:0], 2'b00}; // -2048 + 4k from x8 lands at 0x800
        emit(encS(imm, rs2, 8));
        emit(encI(imm, 8, 3'b010, rd, 7'b0000011));
      end else if (kind < 14) begin
        if (f3[2:1] == 2'b01) f3[2:1] = 2'b10;
        if (alt) rs2 = rs1; // equal operands now and then
        emit(encB(rs2, rs1, f3));
        emit(encI(imm, rs1, 3'b000, rs1, 7'b0010011)); // skipped when taken
      end else if (kind == 14) begin
        emit(encJ(21'd8, rd));
        emit(encI(imm, rs1, 3'b000, rs1, 7'b0010011));
      end else begin
        emit(encU(20'd0, 9, 7'b0010111)); // x9 holds the auipc address
        emit(encI(12'd13, 9, 3'b000, rd, 7'b1100111)); // odd target, bit 0 drops
        emit(encI(imm, rs1, 3'b000, rs1, 7'b0010011));
      end
    end
    for (int r = 0; r < 8; r++) begin
      emit(encS(12'hC00 + 12'(4 * r), r, 8)); // result area, x0 first
    end
    emit(encJ(21'd0, 0)); // jal to itself
    progLen = wp;
  endtask

  function automatic data_t aluModel(input logic [2:0] f3, input logic alt, input data_t a, b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return data_t'($signed(a) < $signed(b));
      3'b011: return data_t'(a < b);
      3'b100: return a ^ b;
      3'b101: return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic runModel();
    data_t      x [32];
    data_t      ins;
    data_t      a;
    data_t      b;
    data_t      res;
    data_t      immI;
    data_t      immB;
    data_t      immJ;
    addr_t      addr;
    addr_t      pc;
    addr_t      nextPc;
    logic [2:0] f3;
    logic       taken;
    foreach (x[i]) x[i] = '0;
    pc = `RESET_PC;
    expectedStores = 0;
    for (int step = 0; step < MemWords; step++) begin
      ins = refMem[pc[11:2]];
      if (ins == 32'h0000_006F) break; // parked on jal x0, 0
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      f3 = ins[14:12];
      immI = {{20{ins[31]}}, ins[31:20]};
      immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      res = pc + 4; // link value for jal and jalr
      nextPc = pc + 4;
      case (ins[6:0])
        7'b0110011: res = aluModel(f3, ins[30], a, b);
        7'b0010011: res = aluModel(f3, ins[30] && f3 == 3'b101, a, immI);
        7'b0000011: begin
          addr = a + immI;
          res = refMem[addr[11:2]];
        end
        7'b0100011: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          refMem[addr[11:2]] = b;
          scoreboard.expectStore(addr, b);
          expectedStores++;
        end
        7'b1100011: begin
          case (f3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) nextPc = pc + immB;
        end
        7'b1101111: nextPc = pc + immJ;
        7'b1100111: nextPc = (a + immI) & ~addr_t'(1);
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b0010111: res = pc + {ins[31:12], 12'b0};
        default: ;
      endcase
      // stores and branches have no destination
      if (ins[6:0] != 7'b0100011 && ins[6:0] != 7'b1100011 && ins[11:7] != 5'd0) begin
        x[ins[11:7]] = res;
      end
      pc = nextPc;
    end
  endtask

  initial begin
    reset = 1'b1;
    lfsr = 32'd49;
    passCount = 0;
    failCount = 0;
    fillMemory();
    for (int t = 0; t < NumTests; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      scoreboard.clearTest();
      buildProgram();
      runModel();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      testId = t;
      deadline = $time + 2 * 5 * progLen * ClkPeriod;
      running = 1'b1;
      wait (scoreboard.seenCount >= expectedStores);
      running = 1'b0;
      if (scoreboard.errorCount == 0) begin
        passCount++;
        $display("test %0d passed, %0d instructions, %0d stores", t, progLen, expectedStores);
      end else begin
        failCount++;
        $display("test %0d failed, %0d of %0d stores wrong", t, scoreboard.errorCount,
                 expectedStores);
      end
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    while (!(running && $time > deadline)) @(posedge clk);
    $display("test %0d hung, only %0d of %0d stores arrived in time", testId,
             scoreboard.seenCount, expectedStores);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* testbench/storeChecker.sv */
// store checker comparing each memory write at the core ports
// in order with the stores queued by the reference model
`timescale 1ns/1ps

module storeChecker (
  input logic           clk,
  input logic           reset,
  input logic           memWrite,
  input rv32Pkg::addr_t memAddr,
  input rv32Pkg::data_t memWriteData
);
  import rv32Pkg::*;

  addr_t expAddr [$];
  data_t expData [$];
  int    seenCount = 0;  // stores seen in the current test
  int    errorCount = 0; // wrong stores in the current test

  task automatic clearTest();
    expAddr.delete();
    expData.delete();
    seenCount = 0;
    errorCount = 0;
  endtask

  task automatic expectStore(input addr_t addr, input data_t data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // write strobe sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && memWrite === 1'b1) begin
      if (expAddr.size() == 0) begin
        $display("store of %h to %h at %0t ns came after the last expected store",
                 memWriteData, memAddr, $time);
        errorCount++;
      end else begin
        if (memAddr !== expAddr[0] || memWriteData !== expData[0]) begin
          $display("FAIL %0t ns: store %0d expected %h at %h, got %h at %h", $time,
                   seenCount, expData[0], expAddr[0], memWriteData, memAddr);
          errorCount++;
        end
        void'(expAddr.pop_front());
        void'(expData.pop_front());
      end
      seenCount++;
    end
  end

endmodule

/* logic/multicycleCore.sv */
// RV32I multicycle core top, control FSM joined to the datapath
`timescale 1ns/1ps

module multicycleCore (
  input  logic           clk,
  input  logic           reset,
  output rv32Pkg::addr_t memAddr,
  output rv32Pkg::data_t memWriteData,
  output logic           memWrite,
  input  rv32Pkg::data_t memReadData
);
  import rv32Pkg::*;

  controlIf ctrlBus ();

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       zeroFlag;
  data_t      aluResult;

  assign memWrite = ctrlBus.memWrite; // store strobe straight from the FSM

  controlFsm fsm (
    .clk(clk), .reset(reset), .opcode(opcode), .funct3(funct3),
    .zeroFlag(zeroFlag), .aluResult(aluResult), .ctrl(ctrlBus.fsm)
  );

  coreDatapath datapath (
    .clk(clk), .reset(reset), .ctrl(ctrlBus.path), .opcode(opcode),
    .funct3(funct3), .zeroFlag(zeroFlag), .aluResult(aluResult),
    .memAddr(memAddr), .memWriteData(memWriteData), .memReadData(memReadData)
  );

endmodule

/* logic/coreDatapath.sv */
// multicycle datapath: PC and holding registers, immediates, muxes,
// ALU and register file
`timescale 1ns/1ps
`include "rv32Params.svh"

module coreDatapath (
  input  logic             clk,
  input  logic             reset,
  controlIf.path           ctrl,
  output rv32Pkg::opcode_t opcode,
  output logic [2:0]       funct3,
  output logic             zeroFlag,
  output rv32Pkg::data_t   aluResult,
  output rv32Pkg::addr_t   memAddr,
  output rv32Pkg::data_t   memWriteData,
  input  rv32Pkg::data_t   memReadData
);
  import rv32Pkg::*;

  addr_t pc, oldPc, pcNext;
  data_t instr;
  data_t data;    // load data captured in MemRead
  data_t aluOut;
  data_t immExt;
  data_t rd1, rd2;
  data_t srcA, srcB;
  data_t result;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  always_comb begin
    case (opcode)
      ITypeLogic, ITypeLoad, ITypeJalr: immExt = {{20{instr[31]}}, instr[31:20]};
      SType:  immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BType:  immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
      JType:  immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
      UTypeLui, UTypeAuipc: immExt = {instr[31:12], 12'b0};
      default: immExt = '0;
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcA)
      SrcAPc:    srcA = pc;
      SrcAOldPc: srcA = oldPc;
      SrcARd1:   srcA = rd1;
      default:   srcA = '0; // lui
    endcase
    case (ctrl.aluSrcB)
      SrcBImm:  srcB = immExt;
      SrcBFour: srcB = data_t'(4);
      default:  srcB = rd2;
    endcase
    case (ctrl.resultSrc)
      ResultData:    result = data;
      ResultAluLive: result = aluResult;
      default:       result = aluOut;
    endcase
    case (ctrl.pcSrc)
      PcSrcJump:      pcNext = aluOut;
      PcSrcAluResult: pcNext = {aluResult[`XLEN-1:1], 1'b0};
      default:        pcNext = result; // pc + 4 from fetch
    endcase
  end

  assign memAddr      = (ctrl.adrSrc == AdrSrcPc) ? pc : result;
  assign memWriteData = rd2;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (ctrl.pcUpdate) begin
      pc <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      instr <= memReadData;
      oldPc <= pc; // address of the instruction being run
    end
    aluOut <= aluResult;
    data   <= memReadData;
  end

  registerFile regFile (
    .clk(clk), .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
    .writeEnable(ctrl.regWrite), .writeData(result), .rd1(rd1), .rd2(rd2)
  );

  aluUnit alu (
    .aluOp(ctrl.aluOp), .funct3(funct3), .funct7b5(instr[30]), .opB5(instr[5]),
    .a(srcA), .b(srcB), .result(aluResult), .zero(zeroFlag)
  );

  pcWordAligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

/* logic/controlFsm.sv */
// multicycle control FSM with per-state control outputs and branch decision
`timescale 1ns/1ps

module controlFsm (
  input  logic            clk,
  input  logic            reset,
  input  rv32Pkg::opcode_t opcode,
  input  logic [2:0]      funct3,
  input  logic            zeroFlag,
  input  rv32Pkg::data_t  aluResult,
  controlIf.fsm           ctrl
);
  import rv32Pkg::*;

  typedef enum logic [3:0] {
    Fetch, Decode, ExecuteR, UncondJump, ExecuteI, MemAdr, AluWb, MemWrite,
    MemRead, MemWb, BranchIfEq, Lui, Auipc, JalrCalc, JalrStep2, BranchComp
  } fsmState_t;

  fsmState_t state, nextState;

  logic eqTaken;
  logic cmpTaken;

  // funct3[0] inverts the sense: bne, bge, bgeu
  assign eqTaken  = zeroFlag ^ funct3[0];
  assign cmpTaken = (aluResult == data_t'(1)) ^ funct3[0];

  always_comb begin
    nextState = Fetch;
    case (state)
      Fetch: nextState = Decode;
      Decode: begin
        case (opcode)
          RType:      nextState = ExecuteR;
          ITypeLogic: nextState = ExecuteI;
          ITypeLoad,
          SType:      nextState = MemAdr;
          BType:      nextState = (funct3[2:1] == 2'b00) ? BranchIfEq : BranchComp;
          JType:      nextState = UncondJump;
          ITypeJalr:  nextState = JalrCalc;
          UTypeLui:   nextState = Lui;
          UTypeAuipc: nextState = Auipc;
          default:    nextState = Decode; // unknown opcode stalls here
        endcase
      end
      ExecuteR, ExecuteI, Lui, Auipc, UncondJump, JalrStep2: nextState = AluWb;
      MemAdr:   nextState = (opcode == ITypeLoad) ? MemRead : MemWrite;
      MemRead:  nextState = MemWb;
      JalrCalc: nextState = JalrStep2;
      default:  nextState = Fetch; // writebacks, store and branches end here
    endcase
  end

  always_comb begin
    ctrl.adrSrc    = AdrSrcPc;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.pcSrc     = PcSrcIncrement;
    ctrl.memWrite  = 1'b0;
    ctrl.aluSrcA   = SrcARd1;
    ctrl.aluSrcB   = SrcBRd2;
    ctrl.aluOp     = AluOpAdd;
    ctrl.resultSrc = ResultAluOut;

    case (state)
      Fetch: begin // pc + 4 goes out on the result bus
        ctrl.irWrite   = 1'b1;
        ctrl.pcUpdate  = 1'b1;
        ctrl.aluSrcA   = SrcAPc;
        ctrl.aluSrcB   = SrcBFour;
        ctrl.resultSrc = ResultAluLive;
      end
      Decode: begin // branch and jal target into ALU out
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBImm;
      end
      ExecuteR: ctrl.aluOp = AluOpRType;
      ExecuteI: begin
        ctrl.aluSrcB = SrcBImm;
        ctrl.aluOp   = AluOpIType;
      end
      Lui: begin
        ctrl.aluSrcA = SrcAZero;
        ctrl.aluSrcB = SrcBImm;
      end
      Auipc: begin
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBImm;
      end
      UncondJump: begin // link computed while PC takes the target
        ctrl.aluSrcA  = SrcAOldPc;
        ctrl.aluSrcB  = SrcBFour;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = PcSrcJump;
      end
      JalrCalc: begin
        ctrl.aluSrcB  = SrcBImm;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = PcSrcAluResult; // rs1 + imm with bit 0 cleared
      end
      JalrStep2: begin
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBFour;
      end
      MemAdr: ctrl.aluSrcB = SrcBImm;
      MemRead: ctrl.adrSrc = AdrSrcResult;
      MemWrite: begin
        ctrl.adrSrc   = AdrSrcResult;
        ctrl.memWrite = 1'b1;
      end
      MemWb: begin
        ctrl.resultSrc = ResultData;
        ctrl.regWrite  = 1'b1;
      end
      AluWb: ctrl.regWrite = 1'b1;
      BranchIfEq: begin
        ctrl.aluOp    = AluOpBranch;
        ctrl.pcUpdate = eqTaken;
        ctrl.pcSrc    = eqTaken ? PcSrcJump : PcSrcIncrement;
      end
      BranchComp: begin
        ctrl.aluOp    = AluOpBranch;
        ctrl.pcUpdate = cmpTaken;
        ctrl.pcSrc    = cmpTaken ? PcSrcJump : PcSrcIncrement;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= Fetch;
    end else begin
      state <= nextState;
    end
  end

  // a write-back cycle never drives the memory strobe
  noWriteOverlap: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.regWrite && ctrl.memWrite));

  irWriteOnlyInFetch: assert property (@(posedge clk) disable iff (reset)
    ctrl.irWrite |-> (state == Fetch));

endmodule

/* logic/registerFile.sv */
// 32-entry register file, two combinational reads and one synchronous write
`timescale 1ns/1ps
`include "rv32Params.svh"

module registerFile (
  input  logic            clk,
  input  rv32Pkg::regIdx_t rs1,
  input  rv32Pkg::regIdx_t rs2,
  input  rv32Pkg::regIdx_t rd,
  input  logic            writeEnable,
  input  rv32Pkg::data_t  writeData,
  output rv32Pkg::data_t  rd1,
  output rv32Pkg::data_t  rd2
);
  import rv32Pkg::*;

  data_t regs [`REG_COUNT];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (writeEnable && (rd != '0)) begin
      regs[rd] <= writeData;
    end
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads as zero
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/aluUnit.sv */
// ALU decoder and 32-bit ALU with zero flag
`timescale 1ns/1ps

module aluUnit (
  input  rv32Pkg::aluOp_t aluOp,
  input  logic [2:0]      funct3,
  input  logic            funct7b5,
  input  logic            opB5,
  input  rv32Pkg::data_t  a,
  input  rv32Pkg::data_t  b,
  output rv32Pkg::data_t  result,
  output logic            zero
);
  import rv32Pkg::*;

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSll, AluSrl, AluSra, AluSlt, AluSltu
  } aluCtrl_t;

  aluCtrl_t aluCtrl;
  logic     isRType;

  assign isRType = (aluOp == AluOpRType) && opB5; // addi never subtracts

  always_comb begin
    aluCtrl = AluAdd;
    case (aluOp)
      AluOpAdd: aluCtrl = AluAdd;
      AluOpBranch: begin
        case (funct3[2:1])
          2'b10:   aluCtrl = AluSlt;  // blt, bge
          2'b11:   aluCtrl = AluSltu; // bltu, bgeu
          default: aluCtrl = AluSub;  // beq, bne
        endcase
      end
      default: begin
        case (funct3)
          3'b000: aluCtrl = (isRType && funct7b5) ? AluSub : AluAdd;
          3'b001: aluCtrl = AluSll;
          3'b010: aluCtrl = AluSlt;
          3'b011: aluCtrl = AluSltu;
          3'b100: aluCtrl = AluXor;
          3'b101: aluCtrl = funct7b5 ? AluSra : AluSrl;
          3'b110: aluCtrl = AluOr;
          default: aluCtrl = AluAnd;
        endcase
      end
    endcase
  end

  always_comb begin
    case (aluCtrl)
      AluSub:  result = a - b;
      AluAnd:  result = a & b;
      AluOr:   result = a | b;
      AluXor:  result = a ^ b;
      AluSll:  result = a << b[4:0];
      AluSrl:  result = a >> b[4:0];
      AluSra:  result = data_t'($signed(a) >>> b[4:0]);
      AluSlt:  result = data_t'($signed(a) < $signed(b));
      AluSltu: result = data_t'(a < b);
      default: result = a + b;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* logic/controlIf.sv */
// control bundle driven by the FSM into the datapath
`timescale 1ns/1ps

interface controlIf;
  import rv32Pkg::*;

  adrSrc_t    adrSrc;
  logic       irWrite;   // latch instruction and old PC
  logic       regWrite;
  logic       pcUpdate;
  pcSrc_t     pcSrc;
  logic       memWrite;
  aluSrcA_t   aluSrcA;
  aluSrcB_t   aluSrcB;
  aluOp_t     aluOp;
  resultSrc_t resultSrc;

  modport fsm (output adrSrc, irWrite, regWrite, pcUpdate, pcSrc, memWrite,
               aluSrcA, aluSrcB, aluOp, resultSrc);

  modport path (input adrSrc, irWrite, regWrite, pcUpdate, pcSrc, memWrite,
                aluSrcA, aluSrcB, aluOp, resultSrc);

endinterface

/* logic/rv32Pkg.sv */
// shared data types, opcode encoding and datapath select encodings
`include "rv32Params.svh"

package rv32Pkg;

  typedef logic [`XLEN-1:0] data_t;
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

  // base opcodes handled by the core
  typedef enum logic [6:0] {
    RType      = 7'b0110011,
    ITypeLogic = 7'b0010011,
    ITypeLoad  = 7'b0000011,
    SType      = 7'b0100011,
    BType      = 7'b1100011,
    JType      = 7'b1101111,
    ITypeJalr  = 7'b1100111,
    UTypeLui   = 7'b0110111,
    UTypeAuipc = 7'b0010111
  } opcode_t;

  typedef enum logic {AdrSrcPc, AdrSrcResult} adrSrc_t;

  // increment takes the result bus, jump takes the ALU-out register
  typedef enum logic [1:0] {PcSrcIncrement, PcSrcJump, PcSrcAluResult} pcSrc_t;

  typedef enum logic [1:0] {SrcAPc, SrcAOldPc, SrcARd1, SrcAZero} aluSrcA_t;
  typedef enum logic [1:0] {SrcBRd2, SrcBImm, SrcBFour} aluSrcB_t;
  typedef enum logic [1:0] {ResultAluOut, ResultData, ResultAluLive} resultSrc_t;

  typedef logic [1:0] aluOp_t;
  localparam aluOp_t AluOpAdd    = 2'b00;
  localparam aluOp_t AluOpBranch = 2'b01; // compare for branches
  localparam aluOp_t AluOpRType  = 2'b10;
  localparam aluOp_t AluOpIType  = 2'b11;

endpackage

/* include/rv32Params.svh */
// core-wide width, register count and reset vector macros
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
